/* Bender.yml */
package:
  name: correlator_channel

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/corr_pkg.sv
      - hdl/channel_regfile.sv
      - hdl/channel_code_gen.sv
      - hdl/channel_carrier_nco.sv
      - hdl/channel_accumulator.sv
      - hdl/correlator_channel.sv
  - target: test
    files:
      - test/tb_correlator_channel.sv

/* correlator_channel.f */
+incdir+hdl
hdl/corr_pkg.sv
hdl/channel_regfile.sv
hdl/channel_code_gen.sv
hdl/channel_carrier_nco.sv
hdl/channel_accumulator.sv
hdl/correlator_channel.sv
test/tb_correlator_channel.sv

/* hdl/channel_accumulator.sv */
module channel_accumulator
    import corr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    doinit,
    input  logic    sample_valid,
    input  sample_t sample,
    input  level_t  cos_level,
    input  level_t  sin_level,
    input  logic    code_bit,
    input  logic    epoch,
    output accum_t  prompt_i,
    output accum_t  prompt_q
);

    logic signed [2:0] magnitude;
    logic signed [2:0] sample_val;
    logic signed [3:0] prod_i;
    logic signed [3:0] prod_q;
    logic signed [3:0] wiped_i;
    logic signed [3:0] wiped_q;
    accum_t            acc_i;
    accum_t            acc_q;
    accum_t            sum_i;
    accum_t            sum_q;

    // sample to +-1 or +-3
    assign magnitude  = sample[0] ? 3'sd3 : 3'sd1;
    assign sample_val = sample[1] ? -magnitude : magnitude;

    // carrier wipe-off, at most 6 in size
    assign prod_i = sample_val * cos_level;
    assign prod_q = sample_val * sin_level;

    // code wipe-off, chip 0 flips the sign
    assign wiped_i = code_bit ? prod_i : -prod_i;
    assign wiped_q = code_bit ? prod_q : -prod_q;

    assign sum_i = acc_i + wiped_i;
    assign sum_q = acc_q + wiped_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_i    <= '0;
            acc_q    <= '0;
            prompt_i <= '0;
            prompt_q <= '0;
        end else if (doinit) begin
            // dump keeps the last epoch
            acc_i <= '0;
            acc_q <= '0;
        end else if (sample_valid) begin
            if (epoch) begin
                // epoch sample belongs to the closing period
                prompt_i <= sum_i;
                prompt_q <= sum_q;
                acc_i    <= '0;
                acc_q    <= '0;
            end else begin
                acc_i <= sum_i;
                acc_q <= sum_q;
            end
        end
    end

endmodule

/* hdl/channel_carrier_nco.sv */
`include "corr_params.svh"

module channel_carrier_nco
    import corr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      doinit,
    input  logic      sample_valid,
    input  nco_word_t phase_rate,
    output level_t    cos_level,
    output level_t    sin_level
);

    // one entry per eighth of a carrier cycle
    localparam level_t COS_TABLE [`CORR_TABLE_SIZE] = '{
        3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1, 3'sd0, 3'sd1
    };
    localparam level_t SIN_TABLE [`CORR_TABLE_SIZE] = '{
        3'sd0, 3'sd1, 3'sd2, 3'sd1, 3'sd0, -3'sd1, -3'sd2, -3'sd1
    };

    nco_word_t                   phase;
    logic [`CORR_PHASE_BITS-1:0] phase_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (doinit) begin
            phase <= '0;
        end else if (sample_valid) begin
            phase <= phase + phase_rate;
        end
    end

    assign phase_idx = phase[`CORR_NCO_WIDTH-1 -: `CORR_PHASE_BITS];

    // levels follow the registered phase
    assign cos_level = COS_TABLE[phase_idx];
    assign sin_level = SIN_TABLE[phase_idx];

endmodule

/* hdl/channel_code_gen.sv */
`include "corr_params.svh"

module channel_code_gen
    import corr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      doinit,
    input  logic      sample_valid,
    input  nco_word_t code_rate,
    input  lfsr_t     code_init,
    input  lfsr_t     code_taps,
    input  prn_len_t  prn_length,
    output logic      code_bit,
    output logic      epoch
);

    nco_word_t code_nco;
    nco_word_t nco_sum;
    logic      nco_carry;
    logic      shift;
    logic      feedback;
    lfsr_t     lfsr;
    lfsr_t     lfsr_shifted;
    prn_len_t  chip_cnt;
    prn_len_t  chip_next;

    // carry out of the code NCO steps the code by one chip
    assign {nco_carry, nco_sum} = {1'b0, code_nco} + {1'b0, code_rate};
    assign shift = sample_valid && nco_carry;

    // taps select the parity inputs, feedback enters at the top
    assign feedback     = ^(lfsr & code_taps);
    assign lfsr_shifted = {feedback, lfsr[`CORR_LFSR_WIDTH-1:1]};

    assign chip_next = chip_cnt + 1'b1;
    assign epoch     = shift && !doinit && (chip_next == prn_length);
    assign code_bit  = lfsr[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_nco <= '0;
        end else if (doinit) begin
            code_nco <= '0;
        end else if (sample_valid) begin
            code_nco <= nco_sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr     <= '0;
            chip_cnt <= '0;
        end else if (doinit) begin
            lfsr     <= code_init;
            chip_cnt <= '0;
        end else if (epoch) begin
            // end of code period, restart the sequence
            lfsr     <= code_init;
            chip_cnt <= '0;
        end else if (shift) begin
            lfsr     <= lfsr_shifted;
            chip_cnt <= chip_next;
        end
    end

endmodule

/* hdl/channel_regfile.sv */
`include "corr_params.svh"

module channel_regfile
    import corr_pkg::*;
#(
    parameter reg_addr_t BASE_ADDR = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we_en,
    input  logic      rd_en,
    input  reg_addr_t reg_addr,
    input  reg_data_t wdata,
    input  logic      epoch,
    input  accum_t    prompt_i,
    input  accum_t    prompt_q,
    output reg_data_t rdata,
    output logic      epoch_irq,
    output logic      doinit,
    output nco_word_t code_rate,
    output nco_word_t phase_rate,
    output lfsr_t     code_init,
    output lfsr_t     code_taps,
    output prn_len_t  prn_length
);

    localparam int EXT_WIDTH = `CORR_DATA_WIDTH - `CORR_ACC_WIDTH;

    reg_addr_t   offset;
    reg_data_t   read_word;
    logic [15:0] epoch_count;
    logic        dump_pending;
    logic        rd_prompt_q;

    // wraps, so a base near the top of the map still decodes
    assign offset = reg_addr - BASE_ADDR;

    assign rd_prompt_q = rd_en && (offset == `CORR_REG_PROMPT_Q);

    // configuration registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_rate  <= '0;
            phase_rate <= '0;
            code_init  <= '0;
            code_taps  <= '0;
            prn_length <= '0;
        end else if (we_en) begin
            case (offset)
                `CORR_REG_CODE_RATE:  code_rate  <= wdata[`CORR_NCO_WIDTH-1:0];
                `CORR_REG_PHASE_RATE: phase_rate <= wdata[`CORR_NCO_WIDTH-1:0];
                `CORR_REG_CODE_INIT:  code_init  <= wdata[`CORR_LFSR_WIDTH-1:0];
                `CORR_REG_CODE_TAPS:  code_taps  <= wdata[`CORR_LFSR_WIDTH-1:0];
                `CORR_REG_PRN_LENGTH: prn_length <= wdata[`CORR_LEN_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // CTRL bit 0 is a command, one cycle of doinit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            doinit <= 1'b0;
        end else begin
            doinit <= we_en && (offset == `CORR_REG_CTRL) && wdata[0];
        end
    end

    // epoch count and pending flag survive doinit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epoch_count  <= '0;
            dump_pending <= 1'b0;
        end else begin
            if (epoch) begin
                epoch_count <= epoch_count + 1'b1;
            end
            // a new dump beats a read on the same edge
            if (epoch) begin
                dump_pending <= 1'b1;
            end else if (rd_prompt_q) begin
                dump_pending <= 1'b0;
            end
        end
    end

    assign epoch_irq = dump_pending;

    always_comb begin
        case (offset)
            `CORR_REG_CODE_RATE:  read_word = reg_data_t'(code_rate);
            `CORR_REG_PHASE_RATE: read_word = reg_data_t'(phase_rate);
            `CORR_REG_CODE_INIT:  read_word = reg_data_t'(code_init);
            `CORR_REG_CODE_TAPS:  read_word = reg_data_t'(code_taps);
            `CORR_REG_PRN_LENGTH: read_word = reg_data_t'(prn_length);
            `CORR_REG_PROMPT_I:
                read_word = {{EXT_WIDTH{prompt_i[`CORR_ACC_WIDTH-1]}}, prompt_i};
            `CORR_REG_PROMPT_Q:
                read_word = {{EXT_WIDTH{prompt_q[`CORR_ACC_WIDTH-1]}}, prompt_q};
            `CORR_REG_STATUS:
                read_word = {{(`CORR_DATA_WIDTH - 17){1'b0}}, dump_pending, epoch_count};
            // CTRL and holes read zero
            default:              read_word = '0;
        endcase
    end

    // held until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= read_word;
        end
    end

endmodule

/* hdl/corr_params.svh */
`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

// bus widths
`define CORR_ADDR_WIDTH 8
`define CORR_DATA_WIDTH 32

// datapath widths
`define CORR_NCO_WIDTH 32
`define CORR_LFSR_WIDTH 10
`define CORR_LEN_WIDTH 12
`define CORR_ACC_WIDTH 16

// carrier table addressed by the top NCO bits
`define CORR_PHASE_BITS 3
`define CORR_TABLE_SIZE (1 << `CORR_PHASE_BITS)

// register offsets from the channel base
`define CORR_REG_CTRL 8'h00
`define CORR_REG_CODE_RATE 8'h04
`define CORR_REG_PHASE_RATE 8'h08
`define CORR_REG_CODE_INIT 8'h0C
`define CORR_REG_CODE_TAPS 8'h10
`define CORR_REG_PRN_LENGTH 8'h14
`define CORR_REG_PROMPT_I 8'h18
`define CORR_REG_PROMPT_Q 8'h1C
`define CORR_REG_STATUS 8'h20

`endif

/* hdl/corr_pkg.sv */
`include "corr_params.svh"

package corr_pkg;

    // host bus
    typedef logic [`CORR_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`CORR_DATA_WIDTH-1:0] reg_data_t;

    // NCO rate or phase word
    typedef logic [`CORR_NCO_WIDTH-1:0] nco_word_t;

    // PRN state or tap mask, and period in chips
    typedef logic [`CORR_LFSR_WIDTH-1:0] lfsr_t;
    typedef logic [`CORR_LEN_WIDTH-1:0] prn_len_t;

    // sign-magnitude sample, bit 1 sign, bit 0 selects 3 over 1
    typedef logic [1:0] sample_t;

    // carrier level, -2 to +2
    typedef logic signed [2:0] level_t;

    // wrapping I/Q accumulator
    typedef logic signed [`CORR_ACC_WIDTH-1:0] accum_t;

endpackage

/* hdl/correlator_channel.sv */
module correlator_channel
    import corr_pkg::*;
#(
    parameter reg_addr_t BASE_ADDR = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we_en,
    input  logic      rd_en,
    input  reg_addr_t reg_addr,
    input  reg_data_t wdata,
    input  sample_t   sample,
    input  logic      sample_valid,
    output reg_data_t rdata,
    output logic      epoch_irq
);

    logic      doinit;
    nco_word_t code_rate;
    nco_word_t phase_rate;
    lfsr_t     code_init;
    lfsr_t     code_taps;
    prn_len_t  prn_length;
    logic      code_bit;
    logic      epoch;
    level_t    cos_level;
    level_t    sin_level;
    accum_t    prompt_i;
    accum_t    prompt_q;

    channel_regfile #(
        .BASE_ADDR (BASE_ADDR)
    ) channel_regfile_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .we_en      (we_en),
        .rd_en      (rd_en),
        .reg_addr   (reg_addr),
        .wdata      (wdata),
        .epoch      (epoch),
        .prompt_i   (prompt_i),
        .prompt_q   (prompt_q),
        .rdata      (rdata),
        .epoch_irq  (epoch_irq),
        .doinit     (doinit),
        .code_rate  (code_rate),
        .phase_rate (phase_rate),
        .code_init  (code_init),
        .code_taps  (code_taps),
        .prn_length (prn_length)
    );

    channel_code_gen channel_code_gen_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .doinit       (doinit),
        .sample_valid (sample_valid),
        .code_rate    (code_rate),
        .code_init    (code_init),
        .code_taps    (code_taps),
        .prn_length   (prn_length),
        .code_bit     (code_bit),
        .epoch        (epoch)
    );

    channel_carrier_nco channel_carrier_nco_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .doinit       (doinit),
        .sample_valid (sample_valid),
        .phase_rate   (phase_rate),
        .cos_level    (cos_level),
        .sin_level    (sin_level)
    );

    channel_accumulator channel_accumulator_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .doinit       (doinit),
        .sample_valid (sample_valid),
        .sample       (sample),
        .cos_level    (cos_level),
        .sin_level    (sin_level),
        .code_bit     (code_bit),
        .epoch        (epoch),
        .prompt_i     (prompt_i),
        .prompt_q     (prompt_q)
    );

endmodule

/* test/tb_correlator_channel.sv */
`include "corr_params.svh"

module tb_correlator_channel
    import corr_pkg::*;
();

    localparam reg_addr_t BASE_ADDR = 8'h40;
    // reset, readback, code period, overwrite, four random epochs, doinit
    localparam int CYCLE_LIMIT = 2 * (8 + 90 + 70 + 130 + 480 + 120);
    localparam logic [1:0] MODE_OFF = 2'd0;
    localparam logic [1:0] MODE_CONST = 2'd1;
    localparam logic [1:0] MODE_FULL = 2'd2;
    localparam logic [1:0] MODE_GAPS = 2'd3;
    localparam int COS_TAB [8] = '{2, 1, 0, -1, -2, -1, 0, 1};
    localparam int SIN_TAB [8] = '{0, 1, 2, 1, 0, -1, -2, -1};

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      we_en = 1'b0;
    logic      rd_en = 1'b0;
    reg_addr_t reg_addr = '0;
    reg_data_t wdata = '0;
    sample_t   sample = '0;
    logic      sample_valid = 1'b0;
    reg_data_t rdata;
    logic      epoch_irq;

    logic [1:0]  stream_mode = MODE_OFF;
    logic [31:0] rng_state = 32'hdf33057b;
    logic [31:0] rnd_word;
    int          cycle_count = 0;
    reg_data_t   word;
    reg_data_t   cfg_code_rate;
    reg_data_t   cfg_phase_rate;
    reg_data_t   cfg_init;
    reg_data_t   cfg_taps;
    reg_data_t   cfg_len;

    // reference model state
    nco_word_t   m_code_rate;
    nco_word_t   m_phase_rate;
    nco_word_t   m_code_nco;
    nco_word_t   m_phase;
    lfsr_t       m_init;
    lfsr_t       m_taps;
    lfsr_t       m_lfsr;
    prn_len_t    m_len;
    prn_len_t    m_chips;
    accum_t      m_acc_i;
    accum_t      m_acc_q;
    accum_t      m_dump_i;
    accum_t      m_dump_q;
    logic [15:0] m_epochs;
    logic        m_pending;
    logic        m_doinit_q;
    logic        m_epoch;
    reg_addr_t   m_off;
    logic        check_rd;
    reg_data_t   exp_rdata;

    always #4 clk = ~clk;

    correlator_channel #(
        .BASE_ADDR (BASE_ADDR)
    ) correlator_channel_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .we_en        (we_en),
        .rd_en        (rd_en),
        .reg_addr     (reg_addr),
        .wdata        (wdata),
        .sample       (sample),
        .sample_valid (sample_valid),
        .rdata        (rdata),
        .epoch_irq    (epoch_irq)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rng_state[0]};
            rng_state = lfsr_step(rng_state);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
        end
    end

    // sample source, gaps mode drops about a quarter of the cycles
    always @(posedge clk) begin
        case (stream_mode)
            MODE_CONST: begin
                sample_valid <= 1'b1;
                sample       <= 2'b00;
            end
            MODE_FULL: begin
                take_bits(2, rnd_word);
                sample_valid <= 1'b1;
                sample       <= rnd_word[1:0];
            end
            MODE_GAPS: begin
                take_bits(4, rnd_word);
                sample_valid <= (rnd_word[3:2] != 2'b00);
                sample       <= rnd_word[1:0];
            end
            default: sample_valid <= 1'b0;
        endcase
    end

    function automatic reg_data_t model_read(input reg_addr_t off);
        case (off)
            `CORR_REG_CODE_RATE:  return m_code_rate;
            `CORR_REG_PHASE_RATE: return m_phase_rate;
            `CORR_REG_CODE_INIT:  return reg_data_t'(m_init);
            `CORR_REG_CODE_TAPS:  return reg_data_t'(m_taps);
            `CORR_REG_PRN_LENGTH: return reg_data_t'(m_len);
            `CORR_REG_PROMPT_I:   return reg_data_t'(int'(m_dump_i));
            `CORR_REG_PROMPT_Q:   return reg_data_t'(int'(m_dump_q));
            `CORR_REG_STATUS:     return {15'b0, m_pending, m_epochs};
            default:              return '0;
        endcase
    endfunction

    task automatic apply_sample(input sample_t s);
        int          value;
        int          prod_i;
        int          prod_q;
        logic [2:0]  k;
        logic [32:0] code_sum;
        value = s[0] ? 3 : 1;
        if (s[1]) begin
            value = -value;
        end
        k      = m_phase[`CORR_NCO_WIDTH-1 -: `CORR_PHASE_BITS];
        prod_i = value * COS_TAB[k];
        prod_q = value * SIN_TAB[k];
        // chip 0 inverts
        if (!m_lfsr[0]) begin
            prod_i = -prod_i;
            prod_q = -prod_q;
        end
        m_phase    = m_phase + m_phase_rate;
        code_sum   = m_code_nco + m_code_rate;
        m_code_nco = code_sum[31:0];
        if (code_sum[32]) begin
            m_lfsr  = {^(m_lfsr & m_taps), m_lfsr[`CORR_LFSR_WIDTH-1:1]};
            m_chips = m_chips + 1'b1;
            if (m_chips == m_len) begin
                m_epoch = 1'b1;
                m_lfsr  = m_init;
                m_chips = '0;
            end
        end
        if (m_epoch) begin
            m_dump_i = m_acc_i + prod_i;
            m_dump_q = m_acc_q + prod_q;
            m_acc_i  = '0;
            m_acc_q  = '0;
            m_epochs = m_epochs + 1'b1;
        end else begin
            m_acc_i = m_acc_i + prod_i;
            m_acc_q = m_acc_q + prod_q;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_code_rate  = '0;
            m_phase_rate = '0;
            m_code_nco   = '0;
            m_phase      = '0;
            m_init       = '0;
            m_taps       = '0;
            m_lfsr       = '0;
            m_len        = '0;
            m_chips      = '0;
            m_acc_i      = '0;
            m_acc_q      = '0;
            m_dump_i     = '0;
            m_dump_q     = '0;
            m_epochs     = '0;
            m_pending    = 1'b0;
            m_doinit_q   = 1'b0;
            check_rd     <= 1'b0;
            exp_rdata    <= '0;
        end else begin
            m_off = reg_addr - BASE_ADDR;
            check_rd  <= rd_en;
            exp_rdata <= model_read(m_off);
            m_epoch = 1'b0;
            // doinit lands one cycle after the CTRL write, its sample is lost
            if (m_doinit_q) begin
                m_code_nco = '0;
                m_phase    = '0;
                m_lfsr     = m_init;
                m_chips    = '0;
                m_acc_i    = '0;
                m_acc_q    = '0;
            end else if (sample_valid) begin
                apply_sample(sample);
            end
            if (m_epoch) begin
                m_pending = 1'b1;
            end else if (rd_en && m_off == `CORR_REG_PROMPT_Q) begin
                m_pending = 1'b0;
            end
            m_doinit_q = 1'b0;
            if (we_en) begin
                case (m_off)
                    `CORR_REG_CTRL:       m_doinit_q   = wdata[0];
                    `CORR_REG_CODE_RATE:  m_code_rate  = wdata;
                    `CORR_REG_PHASE_RATE: m_phase_rate = wdata;
                    `CORR_REG_CODE_INIT:  m_init       = wdata[`CORR_LFSR_WIDTH-1:0];
                    `CORR_REG_CODE_TAPS:  m_taps       = wdata[`CORR_LFSR_WIDTH-1:0];
                    `CORR_REG_PRN_LENGTH: m_len        = wdata[`CORR_LEN_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    rdata_check: assert property (@(posedge clk) disable iff (!rst_n)
        check_rd |-> rdata == exp_rdata)
        else abort_run($sformatf("FAILED at %0t: rdata expected %h, got %h",
                                 $time, $sampled(exp_rdata), $sampled(rdata)));

    irq_check: assert property (@(posedge clk) disable iff (!rst_n)
        epoch_irq == m_pending)
        else abort_run($sformatf("FAILED at %0t: epoch_irq expected %b, got %b",
                                 $time, $sampled(m_pending), $sampled(epoch_irq)));

    task automatic write_reg(input reg_addr_t off, input reg_data_t data);
        @(posedge clk);
        we_en    <= 1'b1;
        reg_addr <= BASE_ADDR + off;
        wdata    <= data;
        @(posedge clk);
        we_en <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t off, output reg_data_t data);
        @(posedge clk);
        rd_en    <= 1'b1;
        reg_addr <= BASE_ADDR + off;
        @(posedge clk);
        rd_en <= 1'b0;
        @(posedge clk);
        data = rdata;
    endtask

    task automatic read_results();
        read_reg(`CORR_REG_PROMPT_I, word);
        read_reg(`CORR_REG_PROMPT_Q, word);
        read_reg(`CORR_REG_STATUS, word);
    endtask

    task automatic wait_irq();
        @(posedge clk);
        while (!epoch_irq) begin
            @(posedge clk);
        end
    endtask

    // polls STATUS until n more epochs have gone by
    task automatic wait_epochs(input int n);
        reg_data_t   status;
        logic [15:0] start;
        logic [15:0] passed;
        read_reg(`CORR_REG_STATUS, status);
        start = status[15:0];
        do begin
            read_reg(`CORR_REG_STATUS, status);
            passed = status[15:0] - start;
        end while (passed < n);
    endtask

    task automatic set_stream(input logic [1:0] mode);
        stream_mode <= mode;
    endtask

    initial begin
        take_bits(31, cfg_code_rate);
        cfg_code_rate[31] = 1'b1;
        take_bits(32, cfg_phase_rate);
        cfg_phase_rate[0] = 1'b1;
        take_bits(10, cfg_init);
        cfg_init[0] = 1'b1;
        take_bits(10, cfg_taps);
        cfg_taps[9] = 1'b1;
        take_bits(4, cfg_len);
        cfg_len = cfg_len + 20;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        for (int off = 0; off <= `CORR_REG_STATUS; off += 4) begin
            read_reg(reg_addr_t'(off), word);
        end

        // readback, holes and a CTRL write without doinit
        write_reg(`CORR_REG_CODE_RATE, 32'h1234_5678);
        write_reg(`CORR_REG_PHASE_RATE, 32'h9abc_def0);
        write_reg(`CORR_REG_CODE_INIT, 32'hffff_fc35);
        write_reg(`CORR_REG_CODE_TAPS, 32'h0000_0a5a);
        write_reg(`CORR_REG_PRN_LENGTH, 32'hffff_f123);
        write_reg(8'h24, 32'hffff_ffff);
        write_reg(`CORR_REG_PROMPT_I, 32'h5555_5555);
        write_reg(`CORR_REG_CTRL, 32'h0000_0002);
        for (int off = 0; off <= `CORR_REG_STATUS; off += 4) begin
            read_reg(reg_addr_t'(off), word);
        end
        read_reg(8'h24, word);
        read_reg(8'h3C, word);
        read_reg(8'h02, word);
        read_reg(8'hC0, word);

        // one code period, cos fixed at 2
        write_reg(`CORR_REG_CODE_RATE, 32'h8000_0000);
        write_reg(`CORR_REG_PHASE_RATE, 32'h0);
        write_reg(`CORR_REG_CODE_INIT, 32'h3ff);
        write_reg(`CORR_REG_CODE_TAPS, 32'h204);
        write_reg(`CORR_REG_PRN_LENGTH, 32'd20);
        write_reg(`CORR_REG_CTRL, 32'h1);
        set_stream(MODE_CONST);
        wait_irq();
        read_results();

        // two epochs unread, second dump must show
        set_stream(MODE_FULL);
        wait_epochs(2);
        read_results();

        set_stream(MODE_OFF);
        write_reg(`CORR_REG_CODE_RATE, cfg_code_rate);
        write_reg(`CORR_REG_PHASE_RATE, cfg_phase_rate);
        write_reg(`CORR_REG_CODE_INIT, cfg_init);
        write_reg(`CORR_REG_CODE_TAPS, cfg_taps);
        write_reg(`CORR_REG_PRN_LENGTH, cfg_len);
        write_reg(`CORR_REG_CTRL, 32'h1);
        read_reg(`CORR_REG_PROMPT_Q, word);
        set_stream(MODE_GAPS);
        repeat (4) begin
            wait_irq();
            read_results();
        end

        // restart partway through a 60-sample period
        set_stream(MODE_OFF);
        write_reg(`CORR_REG_CODE_RATE, 32'h8000_0000);
        write_reg(`CORR_REG_PRN_LENGTH, 32'd30);
        write_reg(`CORR_REG_CTRL, 32'h1);
        read_reg(`CORR_REG_PROMPT_Q, word);
        set_stream(MODE_FULL);
        repeat (20) @(posedge clk);
        write_reg(`CORR_REG_CTRL, 32'h1);
        wait_irq();
        read_results();

        set_stream(MODE_OFF);
        repeat (3) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
